// ==== vbin_defines.svh ====
// vbin shared parameters
// pixel width, line length limit and the fixed stream latency

`ifndef VBIN_DEFINES_SVH
`define VBIN_DEFINES_SVH

// pixel word width in bits
`define VBIN_DATA_WIDTH 8

// longest supported line, sizes the line buffer
`define VBIN_LINE_MAX 1024

// column index width
`define VBIN_COL_WIDTH $clog2(`VBIN_LINE_MAX)

// input to output delay in clocks, same in both modes
`define VBIN_LATENCY 4

`endif

// ==== vbin_pkg.sv ====
// vbin types
// mode and FSM state encodings shared by the binning datapath

`default_nettype none

package vbin_pkg;

    // output mode, switched only at a frame boundary
    typedef enum logic {
        MODE_BYPASS = 1'b0,
        MODE_BIN2X2 = 1'b1
    } bin_mode_e;

    // four-phase configuration slave
    typedef enum logic [1:0] {
        CFG_IDLE       = 2'd0,
        CFG_WAIT_FRAME = 2'd1,
        CFG_ACK        = 2'd2,
        CFG_RELEASE    = 2'd3
    } cfg_state_e;

    // input line tracking
    typedef enum logic [1:0] {
        LS_WAIT_FRAME = 2'd0,
        LS_ACTIVE     = 2'd1,
        LS_BLANK      = 2'd2
    } line_state_e;

endpackage

`default_nettype wire

// ==== vbin_sync_decode.sv ====
// vbin sync decoder
// registers the incoming pixel with its qualifiers and derives the
// frame start pulse, the row parity and the column index that go with it

`timescale 1ns/1ps
`default_nettype none

`include "vbin_defines.svh"

module vbin_sync_decode
    import vbin_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire  [`VBIN_DATA_WIDTH-1:0]   di_i,
    input  wire                           de_i,
    input  wire                           hs_i,
    input  wire                           vs_i,
    output logic [`VBIN_DATA_WIDTH-1:0]   pix_d_o,
    output logic                          pix_de_o,
    output logic                          pix_hs_o,
    output logic                          pix_vs_o,
    output logic                          frame_start_o,
    output logic                          row_odd_o,
    output logic [`VBIN_COL_WIDTH-1:0]    col_idx_o
);

    localparam int COL_W = `VBIN_COL_WIDTH;

    line_state_e    state_q;
    line_state_e    state_d;
    // one spare bit so an overlong line is visible
    logic [COL_W:0] col_cnt_q;
    logic           frame_rise;
    logic           line_end;

    // pix_vs_o is vs_i of the previous cycle
    assign frame_rise = vs_i & ~pix_vs_o;
    assign line_end   = (state_q == LS_ACTIVE) & ~de_i;

    // --------------------------------------------------
    // line tracking FSM
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            LS_WAIT_FRAME: begin
                if (frame_rise) begin
                    state_d = LS_BLANK;
                end
            end
            LS_BLANK: begin
                if (de_i) begin
                    state_d = LS_ACTIVE;
                end
            end
            LS_ACTIVE: begin
                if (!de_i) begin
                    state_d = LS_BLANK;
                end
            end
            default: state_d = LS_WAIT_FRAME;
        endcase
        // vertical blanking always returns to the idle state
        if (!vs_i) begin
            state_d = LS_WAIT_FRAME;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q       <= LS_WAIT_FRAME;
            col_cnt_q     <= '0;
            row_odd_o     <= 1'b0;
            frame_start_o <= 1'b0;
            pix_de_o      <= 1'b0;
            pix_hs_o      <= 1'b0;
            pix_vs_o      <= 1'b0;
        end else begin
            state_q       <= state_d;
            frame_start_o <= frame_rise;
            pix_de_o      <= de_i;
            pix_hs_o      <= hs_i;
            pix_vs_o      <= vs_i;

            // column count restarts after every line
            if (frame_rise || line_end) begin
                col_cnt_q <= '0;
            end else if (de_i) begin
                col_cnt_q <= col_cnt_q + 1'b1;
            end

            if (frame_rise) begin
                row_odd_o <= 1'b0;
            end else if (line_end) begin
                row_odd_o <= ~row_odd_o;
            end
        end
    end

    // pixel word and its column
    always_ff @(posedge clk) begin
        pix_d_o   <= di_i;
        col_idx_o <= col_cnt_q[COL_W-1:0];
    end

    a_line_len : assert property (@(posedge clk) disable iff (!rst_n_i)
        de_i |-> (col_cnt_q < `VBIN_LINE_MAX))
        else $error("input line longer than VBIN_LINE_MAX");

endmodule

`default_nettype wire

// ==== vbin_line_buffer.sv ====
// vbin line buffer
// single port line RAM holding the previous row, one word per column
// the old word at the address comes out one clock after the access,
// while the new pixel is written in its place

`timescale 1ns/1ps
`default_nettype none

`include "vbin_defines.svh"

module vbin_line_buffer (
    input  wire                           clk,
    input  wire                           we_i,
    input  wire  [`VBIN_COL_WIDTH-1:0]    addr_i,
    input  wire  [`VBIN_DATA_WIDTH-1:0]   wdata_i,
    output logic [`VBIN_DATA_WIDTH-1:0]   rdata_o
);

    logic [`VBIN_DATA_WIDTH-1:0] mem [0:`VBIN_LINE_MAX-1];

    // read before write on the same address
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== vbin_bin_execute.sv ====
// vbin binning datapath
// stage 1 stores the row in the line buffer and lines up the 2x2 window,
// stage 2 averages the window or forwards the pixel in bypass mode

`timescale 1ns/1ps
`default_nettype none

`include "vbin_defines.svh"

module vbin_bin_execute
    import vbin_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire  bin_mode_e               mode_i,
    input  wire  [`VBIN_DATA_WIDTH-1:0]   pix_d_i,
    input  wire                           pix_de_i,
    input  wire                           pix_hs_i,
    input  wire                           pix_vs_i,
    input  wire                           row_odd_i,
    input  wire  [`VBIN_COL_WIDTH-1:0]    col_idx_i,
    output logic [`VBIN_DATA_WIDTH-1:0]   bin_data_o,
    output logic                          bin_de_o,
    output logic                          bin_hs_o,
    output logic                          bin_vs_o
);

    localparam int W = `VBIN_DATA_WIDTH;

    // window layout
    //   upper row : up_prev_q  up_cur
    //   this row  : prev_q     cur_q
    logic [W-1:0] up_cur;
    logic [W-1:0] up_prev_q;
    logic [W-1:0] prev_q;
    logic [W-1:0] cur_q;
    logic         s1_de;
    logic         s1_hs;
    logic         s1_vs;
    logic         s1_close;
    logic [W+1:0] sum;

    // --------------------------------------------------
    // stage 1, buffer access and window alignment
    // --------------------------------------------------
    vbin_line_buffer u_line_buffer (
        .clk     (clk),
        .we_i    (pix_de_i),
        .addr_i  (col_idx_i),
        .wdata_i (pix_d_i),
        .rdata_o (up_cur)
    );

    // pixels of a line are contiguous, so shifting on de is enough
    always_ff @(posedge clk) begin
        if (pix_de_i) begin
            cur_q     <= pix_d_i;
            prev_q    <= cur_q;
            up_prev_q <= up_cur;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s1_de    <= 1'b0;
            s1_hs    <= 1'b0;
            s1_vs    <= 1'b0;
            s1_close <= 1'b0;
        end else begin
            s1_de    <= pix_de_i;
            s1_hs    <= pix_hs_i;
            s1_vs    <= pix_vs_i;
            // bottom right pixel of a 2x2 block
            s1_close <= row_odd_i & col_idx_i[0];
        end
    end

    // --------------------------------------------------
    // stage 2, sum and divide by four
    // --------------------------------------------------
    // two guard bits hold four full scale pixels
    assign sum = {2'b00, up_prev_q} + {2'b00, up_cur}
               + {2'b00, prev_q} + {2'b00, cur_q};

    always_ff @(posedge clk) begin
        if (mode_i == MODE_BIN2X2) begin
            bin_data_o <= sum[W+1:2];
        end else begin
            bin_data_o <= cur_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bin_de_o <= 1'b0;
            bin_hs_o <= 1'b0;
            bin_vs_o <= 1'b0;
        end else begin
            if (mode_i == MODE_BIN2X2) begin
                bin_de_o <= s1_de & s1_close;
            end else begin
                bin_de_o <= s1_de;
            end
            bin_hs_o <= s1_hs;
            bin_vs_o <= s1_vs;
        end
    end

    // an output pixel must come from inside the active frame
    a_de_in_frame : assert property (@(posedge clk) disable iff (!rst_n_i)
        bin_de_o |-> $past(pix_vs_i, `VBIN_LATENCY - 2))
        else $error("binned pixel outside of the frame");

endmodule

`default_nettype wire

// ==== vbin_mode_ctrl.sv ====
// vbin mode control
// four-phase req/ack slave that takes a requested mode over on the
// next frame start so that every frame runs in a single mode

`timescale 1ns/1ps
`default_nettype none

module vbin_mode_ctrl
    import vbin_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              frame_start_i,
    input  wire              cfg_req_i,
    input  wire  bin_mode_e  cfg_mode_i,
    output logic             cfg_ack_o,
    output bin_mode_e        mode_o
);

    cfg_state_e state_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= CFG_IDLE;
            cfg_ack_o <= 1'b0;
            mode_o    <= MODE_BYPASS;
        end else begin
            case (state_q)
                CFG_IDLE: begin
                    if (cfg_req_i && frame_start_i) begin
                        mode_o    <= cfg_mode_i;
                        cfg_ack_o <= 1'b1;
                        state_q   <= CFG_ACK;
                    end else if (cfg_req_i) begin
                        state_q <= CFG_WAIT_FRAME;
                    end
                end
                CFG_WAIT_FRAME: begin
                    if (!cfg_req_i) begin
                        // request withdrawn before it was served
                        state_q <= CFG_IDLE;
                    end else if (frame_start_i) begin
                        mode_o    <= cfg_mode_i;
                        cfg_ack_o <= 1'b1;
                        state_q   <= CFG_ACK;
                    end
                end
                CFG_ACK: begin
                    if (!cfg_req_i) begin
                        cfg_ack_o <= 1'b0;
                        state_q   <= CFG_RELEASE;
                    end
                end
                CFG_RELEASE: begin
                    // ack is low here and the master may start again
                    state_q <= CFG_IDLE;
                end
                default: state_q <= CFG_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // handshake checks
    // --------------------------------------------------
    a_ack_rise : assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(cfg_ack_o) |-> cfg_req_i)
        else $error("cfg_ack_o raised without a request");

    a_ack_fall : assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(cfg_ack_o) |-> !cfg_req_i)
        else $error("cfg_req_i was high as cfg_ack_o dropped");

endmodule

`default_nettype wire

// ==== vbin_result.sv ====
// vbin output stage
// final register bank for the video stream; the data word only
// changes with an output pixel and holds in between

`timescale 1ns/1ps
`default_nettype none

`include "vbin_defines.svh"

module vbin_result (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire  [`VBIN_DATA_WIDTH-1:0]   bin_data_i,
    input  wire                           bin_de_i,
    input  wire                           bin_hs_i,
    input  wire                           bin_vs_i,
    output logic [`VBIN_DATA_WIDTH-1:0]   do_o,
    output logic                          de_o,
    output logic                          hs_o,
    output logic                          vs_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            do_o <= '0;
            de_o <= 1'b0;
            hs_o <= 1'b0;
            vs_o <= 1'b0;
        end else begin
            // data follows de only
            if (bin_de_i) begin
                do_o <= bin_data_i;
            end
            de_o <= bin_de_i;
            hs_o <= bin_hs_i;
            vs_o <= bin_vs_i;
        end
    end

endmodule

`default_nettype wire

// ==== vbin_top.sv ====
// vbin top level
// streaming 2x2 pixel binning with a bypass mode, four clocks from
// input to output; the mode is set over a four-phase req/ack port

`timescale 1ns/1ps
`default_nettype none

`include "vbin_defines.svh"

module vbin_top
    import vbin_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst_n_i,
    // input stream
    input  wire  [`VBIN_DATA_WIDTH-1:0]   di_i,
    input  wire                           de_i,
    input  wire                           hs_i,
    input  wire                           vs_i,
    // output stream
    output logic [`VBIN_DATA_WIDTH-1:0]   do_o,
    output logic                          de_o,
    output logic                          hs_o,
    output logic                          vs_o,
    // configuration
    input  wire                           cfg_req_i,
    input  wire  bin_mode_e               cfg_mode_i,
    output logic                          cfg_ack_o,
    output bin_mode_e                     mode_o
);

    logic [`VBIN_DATA_WIDTH-1:0] pix_d;
    logic                        pix_de;
    logic                        pix_hs;
    logic                        pix_vs;
    logic                        frame_start;
    logic                        row_odd;
    logic [`VBIN_COL_WIDTH-1:0]  col_idx;
    bin_mode_e                   mode;
    logic [`VBIN_DATA_WIDTH-1:0] bin_data;
    logic                        bin_de;
    logic                        bin_hs;
    logic                        bin_vs;

    assign mode_o = mode;

    vbin_sync_decode u_sync_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .di_i          (di_i),
        .de_i          (de_i),
        .hs_i          (hs_i),
        .vs_i          (vs_i),
        .pix_d_o       (pix_d),
        .pix_de_o      (pix_de),
        .pix_hs_o      (pix_hs),
        .pix_vs_o      (pix_vs),
        .frame_start_o (frame_start),
        .row_odd_o     (row_odd),
        .col_idx_o     (col_idx)
    );

    vbin_mode_ctrl u_mode_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .frame_start_i (frame_start),
        .cfg_req_i     (cfg_req_i),
        .cfg_mode_i    (cfg_mode_i),
        .cfg_ack_o     (cfg_ack_o),
        .mode_o        (mode)
    );

    vbin_bin_execute u_bin_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .mode_i     (mode),
        .pix_d_i    (pix_d),
        .pix_de_i   (pix_de),
        .pix_hs_i   (pix_hs),
        .pix_vs_i   (pix_vs),
        .row_odd_i  (row_odd),
        .col_idx_i  (col_idx),
        .bin_data_o (bin_data),
        .bin_de_o   (bin_de),
        .bin_hs_o   (bin_hs),
        .bin_vs_o   (bin_vs)
    );

    vbin_result u_result (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .bin_data_i (bin_data),
        .bin_de_i   (bin_de),
        .bin_hs_i   (bin_hs),
        .bin_vs_i   (bin_vs),
        .do_o       (do_o),
        .de_o       (de_o),
        .hs_o       (hs_o),
        .vs_o       (vs_o)
    );

endmodule

`default_nettype wire

// ==== tb_vbin.sv ====
// vbin testbench
// runs a table of frames through the binning unit, sets the mode over
// the req/ack port for each entry and checks the output stream against
// a reference model and the input sync delayed by the pipeline

`timescale 1ns/1ps
`default_nettype none

`include "vbin_defines.svh"

module tb_vbin
    import vbin_pkg::*;
();

    localparam int LAT         = `VBIN_LATENCY;
    localparam int W           = `VBIN_DATA_WIDTH;
    localparam int NUM_TESTS   = 4;
    localparam int ACK_TIMEOUT = 200;
    localparam int PAT_RAMP    = 0;
    localparam int PAT_CONST   = 1;
    localparam int PAT_RAND    = 2;

    logic           clk = 1'b0;
    logic           rst_n_i;
    logic [W-1:0]   di_i;
    logic           de_i;
    logic           hs_i;
    logic           vs_i;
    logic [W-1:0]   do_o;
    logic           de_o;
    logic           hs_o;
    logic           vs_o;
    logic           cfg_req_i;
    bin_mode_e      cfg_mode_i;
    logic           cfg_ack_o;
    bin_mode_e      mode_o;

    // expected de_o of the driven cycle and the LAT stage delay lines
    logic           exp_de_in;
    logic [LAT-1:0] hs_dly = '0;
    logic [LAT-1:0] vs_dly = '0;
    logic [LAT-1:0] de_dly = '0;

    logic [W-1:0]   frame_px [$];
    logic [W-1:0]   exp_q [$];
    logic [W-1:0]   got_q [$];
    logic [31:0]    rng;
    int             frame_count;
    string          cur_name;
    bin_mode_e      cur_mode;

    // --------------------------------------------------
    // test table
    // --------------------------------------------------
    string     t_name [NUM_TESTS] = '{"bypass_ramp_8x4", "bin_random_16x6",
                                      "bin_const_7x5", "mid_frame_request"};
    bin_mode_e t_mode [NUM_TESTS] = '{MODE_BYPASS, MODE_BIN2X2,
                                      MODE_BIN2X2, MODE_BYPASS};
    int        t_w    [NUM_TESTS] = '{8, 16, 7, 8};
    int        t_h    [NUM_TESTS] = '{4, 6, 5, 4};
    int        t_pat  [NUM_TESTS] = '{PAT_RAMP, PAT_RAND, PAT_CONST, PAT_RAMP};
    // request raised inside a frame that still runs in the old mode
    bit        t_mid  [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};

    vbin_top u_dut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .di_i       (di_i),
        .de_i       (de_i),
        .hs_i       (hs_i),
        .vs_i       (vs_i),
        .do_o       (do_o),
        .de_o       (de_o),
        .hs_o       (hs_o),
        .vs_o       (vs_o),
        .cfg_req_i  (cfg_req_i),
        .cfg_mode_i (cfg_mode_i),
        .cfg_ack_o  (cfg_ack_o),
        .mode_o     (mode_o)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            fail_run($sformatf("mismatch %s %s expected 0x%0h actual 0x%0h",
                               test, what, exp_v, act_v));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic make_frame(input int pat, input int w, input int h);
        int i;
        frame_px.delete();
        for (i = 0; i < w * h; i++) begin
            case (pat)
                PAT_RAMP:  frame_px.push_back(i[W-1:0]);
                PAT_CONST: frame_px.push_back({W{1'b1}});
                default: begin
                    rng = xorshift(rng);
                    frame_px.push_back(rng[W-1:0]);
                end
            endcase
        end
    endtask

    // reference model with one output per pixel or per 2x2 block
    task automatic build_expected(input bin_mode_e m, input int w, input int h);
        int r;
        int c;
        int sum;
        for (r = 0; r < h; r++) begin
            for (c = 0; c < w; c++) begin
                if (m == MODE_BYPASS) begin
                    exp_q.push_back(frame_px[r * w + c]);
                end else if (r % 2 == 1 && c % 2 == 1) begin
                    sum = frame_px[(r - 1) * w + c - 1] + frame_px[(r - 1) * w + c]
                        + frame_px[r * w + c - 1] + frame_px[r * w + c];
                    exp_q.push_back(sum / 4);
                end
            end
        end
    endtask

    task automatic drive_cycle(input logic de, input logic hs, input logic vs,
                               input logic [W-1:0] d, input logic xde);
        @(posedge clk);
        de_i      <= de;
        hs_i      <= hs;
        vs_i      <= vs;
        di_i      <= d;
        exp_de_in <= xde;
    endtask

    task automatic drive_frame(input bin_mode_e m, input int w, input int h);
        int r;
        int c;
        int b;
        // vertical blanking with vs low ahead of the frame
        repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0);
        frame_count++;
        for (r = 0; r < h; r++) begin
            for (b = 0; b < 4; b++) begin
                drive_cycle(1'b0, b < 2, 1'b1, '0, 1'b0);
            end
            for (c = 0; c < w; c++) begin
                drive_cycle(1'b1, 1'b0, 1'b1, frame_px[r * w + c],
                            m == MODE_BYPASS || (r % 2 == 1 && c % 2 == 1));
            end
        end
        // blanking after the last line and vs low while the pipeline drains
        repeat (4) drive_cycle(1'b0, 1'b0, 1'b1, '0, 1'b0);
        repeat (2 * LAT) drive_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0);
    endtask

    // --------------------------------------------------
    // four-phase master
    // --------------------------------------------------
    task automatic configure_mode(input bin_mode_e new_mode, input bin_mode_e old_mode,
                                  input int lead);
        int waited;
        int frames_at_req;
        repeat (lead + 1) @(posedge clk);
        cfg_mode_i <= new_mode;
        cfg_req_i  <= 1'b1;
        @(negedge clk);
        frames_at_req = frame_count;
        waited = 0;
        while (!cfg_ack_o) begin
            check_value(cur_name, "mode_o before ack", old_mode, mode_o);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                fail_run($sformatf("%s: timeout waiting for cfg_ack_o to rise", cur_name));
            end
            @(negedge clk);
        end
        if (frame_count == frames_at_req) begin
            fail_run($sformatf("%s: cfg_ack_o rose before the next frame start", cur_name));
        end
        check_value(cur_name, "mode_o after ack", new_mode, mode_o);
        @(posedge clk);
        cfg_req_i <= 1'b0;
        @(negedge clk);
        // the slave has not seen the request drop yet
        check_value(cur_name, "cfg_ack_o after req drop", 1, cfg_ack_o);
        waited = 0;
        while (cfg_ack_o) begin
            waited++;
            if (waited > ACK_TIMEOUT) begin
                fail_run($sformatf("%s: timeout waiting for cfg_ack_o to fall", cur_name));
            end
            @(negedge clk);
        end
    endtask

    task automatic compare_outputs();
        if (got_q.size() != exp_q.size()) begin
            fail_run($sformatf("%s: expected %0d output pixels but the DUT gave %0d",
                               cur_name, exp_q.size(), got_q.size()));
        end
        foreach (exp_q[i]) begin
            check_value(cur_name, $sformatf("pixel %0d", i), exp_q[i], got_q[i]);
        end
    endtask

    task automatic run_entry(input int t);
        int        w;
        int        h;
        int        lead;
        bin_mode_e old_mode;
        w        = t_w[t];
        h        = t_h[t];
        old_mode = cur_mode;
        cur_name = t_name[t];
        make_frame(t_pat[t], w, h);
        exp_q.delete();
        got_q.delete();
        if (t_mid[t]) begin
            // lands in the pixels of the middle row of the first frame
            lead = 4 + (h / 2) * (w + 4) + 6;
            build_expected(old_mode, w, h);
            build_expected(t_mode[t], w, h);
            fork
                configure_mode(t_mode[t], old_mode, lead);
                begin
                    drive_frame(old_mode, w, h);
                    drive_frame(t_mode[t], w, h);
                end
            join
        end else begin
            build_expected(t_mode[t], w, h);
            fork
                configure_mode(t_mode[t], old_mode, 0);
                drive_frame(t_mode[t], w, h);
            join
        end
        cur_mode = t_mode[t];
        compare_outputs();
    endtask

    // stream monitor comparing outputs with the inputs of LAT cycles ago
    always @(negedge clk) begin
        if (rst_n_i) begin
            check_value(cur_name, "hs_o", hs_dly[LAT-1], hs_o);
            check_value(cur_name, "vs_o", vs_dly[LAT-1], vs_o);
            check_value(cur_name, "de_o", de_dly[LAT-1], de_o);
            if (de_o) begin
                got_q.push_back(do_o);
            end
        end
        hs_dly = {hs_dly[LAT-2:0], hs_i};
        vs_dly = {vs_dly[LAT-2:0], vs_i};
        de_dly = {de_dly[LAT-2:0], exp_de_in};
    end

    initial begin
        rst_n_i     <= 1'b0;
        di_i        <= '0;
        de_i        <= 1'b0;
        hs_i        <= 1'b0;
        vs_i        <= 1'b0;
        cfg_req_i   <= 1'b0;
        cfg_mode_i  <= MODE_BYPASS;
        exp_de_in   <= 1'b0;
        rng         = 32'hfa0b_e18d;
        frame_count = 0;
        cur_name    = "reset";
        cur_mode    = MODE_BYPASS;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_value(cur_name, "mode_o", MODE_BYPASS, mode_o);
        check_value(cur_name, "cfg_ack_o", 0, cfg_ack_o);
        check_value(cur_name, "de_o", 0, de_o);
        check_value(cur_name, "hs_o", 0, hs_o);
        check_value(cur_name, "vs_o", 0, vs_o);
        check_value(cur_name, "do_o", 0, do_o);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vbin.f ====
+incdir+.
vbin_pkg.sv
vbin_sync_decode.sv
vbin_line_buffer.sv
vbin_bin_execute.sv
vbin_mode_ctrl.sv
vbin_result.sv
vbin_top.sv
tb_vbin.sv

// ==== Bender.yml ====
package:
  name: vbin

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - vbin_pkg.sv
      - vbin_sync_decode.sv
      - vbin_line_buffer.sv
      - vbin_bin_execute.sv
      - vbin_mode_ctrl.sv
      - vbin_result.sv
      - vbin_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vbin.sv
